/* include/bp_defines.svh */
// Width, depth, opcode and register macros for the return prediction front end
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// Address width
`define XLEN 32

// Return address stack entries, pointer wraps at this depth
`define RAS_DEPTH 8

// Class table entries, indexed by PC bits just above the word offset
`define CLASS_DEPTH 16

//////////////////////////////////////////////////
// RV32I control transfer encodings
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define F3_JALR   3'b000

// Link registers ra and t0, plus x0
`define REG_ZERO 5'd0
`define REG_RA   5'd1
`define REG_T0   5'd5

`endif

/* verilog/bpPkg.sv */
// Instruction class struct, J-type and I-type views, instruction word union
package bpPkg;

  // Predicted or decoded class of one instruction
  // At most one bit is set
  typedef struct packed {
    logic ret;
    logic call;
    logic jump;
    logic branch;
  } instrClassT;

  // jal layout, immediate bits left scrambled as in the ISA
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } jTypeT;

  // jalr layout
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  // One 32-bit word, two readings
  typedef union packed {
    jTypeT jView;
    iTypeT iView;
  } instrWordU;

endpackage

/* verilog/instrClassDecode.sv */
// D-stage decoder from instruction word to instruction class
`timescale 1ns/1ps

`include "bp_defines.svh"

module instrClassDecode import bpPkg::*; (
  input  instrWordU  instrD,
  output instrClassT classD
);

  // ra or t0 marks a link register in the calling convention
  function automatic logic isLink(input logic [4:0] r);
    return (r == `REG_RA) || (r == `REG_T0);
  endfunction

  logic jalRdLink;
  logic jalrRdLink;
  logic jalrRs1Link;
  logic jalrRdZero;
  logic isJalr;

  // jal only has rd to look at
  assign jalRdLink = isLink(instrD.jView.rd);

  // jalr fields
  assign jalrRdLink  = isLink(instrD.iView.rd);
  assign jalrRs1Link = isLink(instrD.iView.rs1);
  assign jalrRdZero  = (instrD.iView.rd == `REG_ZERO);

  // funct3 must be zero, other values are reserved
  assign isJalr = (instrD.iView.opcode == `OP_JALR) &&
                  (instrD.iView.funct3 == `F3_JALR);

  //////////////////////////////////////////////////
  // Class selection
  always_comb begin
    classD = '0;
    if (instrD.jView.opcode == `OP_JAL) begin
      // jal with a link rd is a call, otherwise a plain jump
      if (jalRdLink) begin
        classD.call = 1'b1;
      end else begin
        classD.jump = 1'b1;
      end
    end else if (isJalr) begin
      // Return needs link source and no link written
      if (jalrRs1Link && jalrRdZero) begin
        classD.ret = 1'b1;
      end else if (jalrRdLink) begin
        classD.call = 1'b1;
      end else begin
        classD.jump = 1'b1;
      end
    end else if (instrD.iView.opcode == `OP_BRANCH) begin
      classD.branch = 1'b1;
    end
    // Anything else stays all zero
  end

endmodule

/* verilog/classPredictor.sv */
// PC-indexed class table with combinational F read and D-stage training
`timescale 1ns/1ps

`include "bp_defines.svh"

module classPredictor import bpPkg::*; (
  input  logic             clk,
  input  logic             reset,
  // Fetch side lookup
  input  logic [`XLEN-1:0] pcF,
  output instrClassT       predClassF,
  // Training from decode
  input  logic [`XLEN-1:0] pcD,
  input  instrClassT       classD,
  input  logic             update
);

  // Index width follows the table depth
  localparam int IDX_W = $clog2(`CLASS_DEPTH);

  instrClassT classTable [`CLASS_DEPTH];

  logic [IDX_W-1:0] idxF;
  logic [IDX_W-1:0] idxD;

  //////////////////////////////////////////////////
  // Indexing
  // Skip the two byte-offset bits of a word address
  assign idxF = pcF[IDX_W+1:2];
  assign idxD = pcD[IDX_W+1:2];

  // Same-cycle prediction for the fetched PC
  assign predClassF = classTable[idxF];

  //////////////////////////////////////////////////
  // Training
  // Reset makes every entry predict nothing
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CLASS_DEPTH; i++) begin
        classTable[i] <= '0;
      end
    end else if (update) begin
      // Overwrite with the decoded class after a miss
      classTable[idxD] <= classD;
    end
  end

  // A write and a read of the same entry in one cycle
  // give the old value on predClassF until the edge

endmodule

/* verilog/predictPipe.sv */
// F/D and D/E stage registers with valid bits, stall, flush and class miss flag
`timescale 1ns/1ps

`include "bp_defines.svh"

module predictPipe import bpPkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  input  logic             flushE,
  // Fetch stage
  input  logic [`XLEN-1:0] pcF,
  input  instrWordU        instrF,
  input  instrClassT       predClassF,
  // Decode stage
  input  instrClassT       classD,
  output logic [`XLEN-1:0] pcD,
  output instrWordU        instrD,
  output instrClassT       predClassD,
  output logic             validD,
  output logic             classMissD,
  // Execute stage
  output logic [`XLEN-1:0] pcE,
  output instrClassT       classE,
  output logic             validE
);

  logic validDQ;
  logic validEQ;

  //////////////////////////////////////////////////
  // Valid bits
  // Flush wins over stall so a redirect is never lost
  always_ff @(posedge clk) begin
    if (reset) begin
      validDQ <= 1'b0;
      validEQ <= 1'b0;
    end else if (flushE) begin
      validDQ <= 1'b0;
      validEQ <= 1'b0;
    end else if (!stall) begin
      // Fetch always presents an instruction
      validDQ <= 1'b1;
      validEQ <= validDQ;
    end
  end

  //////////////////////////////////////////////////
  // Payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      // F to D
      pcD        <= pcF;
      instrD     <= instrF;
      predClassD <= predClassF;
      // D to E, decoded class travels on
      pcE        <= pcD;
      classE     <= classD;
    end
  end

  // A stage under flush is already dead in this cycle
  // so it neither pushes nor repairs at the coming edge
  assign validD = validDQ & ~flushE;
  assign validE = validEQ & ~flushE;

  // Decoded class against the class predicted at fetch
  assign classMissD = validD & (classD != predClassD);

endmodule

/* verilog/rasPredictor.sv */
// Return address stack with F-stage pop, E-stage push and D-stage pointer repair
`timescale 1ns/1ps

`include "bp_defines.svh"

module rasPredictor import bpPkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  // Fetch stage prediction
  input  instrClassT       predClassF,
  // Decode stage check
  input  instrClassT       predClassD,
  input  instrClassT       classD,
  input  logic             classMissD,
  // Execute stage call
  input  instrClassT       classE,
  input  logic             validE,
  input  logic [`XLEN-1:0] pcE,
  // Predicted return target
  output logic [`XLEN-1:0] rasTargetF
);

  localparam int PTR_W = $clog2(`RAS_DEPTH);

  logic [`XLEN-1:0] stack [`RAS_DEPTH];
  logic [PTR_W-1:0] ptrQ;
  logic [PTR_W-1:0] ptrP1;
  logic [PTR_W-1:0] ptrNext;
  logic [`XLEN-1:0] linkE;

  logic pop;
  logic push;
  logic repair;
  logic repairUp;
  logic repairDown;

  // Net pointer movement, -2 to +2
  logic signed [2:0] step;

  //////////////////////////////////////////////////
  // Events
  // Predicted return leaves the fetch stage
  assign pop = predClassF.ret & ~stall;

  // Live call in E saves its link address
  assign push = classE.call & validE & ~stall;

  // Miss in D, only a return bit mismatch moves the pointer
  assign repair = classMissD & ~stall;

  // Popped for something that was not a return, undo it
  assign repairUp = repair & predClassD.ret & ~classD.ret;

  // Real return that never popped, pop it now
  assign repairDown = repair & ~predClassD.ret & classD.ret;

  //////////////////////////////////////////////////
  // Pointer arithmetic
  always_comb begin
    step = 3'sd0;
    if (push) begin
      step = step + 3'sd1;
    end
    if (repairUp) begin
      step = step + 3'sd1;
    end
    if (pop) begin
      step = step - 3'sd1;
    end
    if (repairDown) begin
      step = step - 3'sd1;
    end
  end

  // Wraps modulo the depth, overflow lands on the oldest entry
  assign ptrNext = ptrQ + PTR_W'(step);

  // Push is the oldest event in the cycle, so it writes above the current top
  assign ptrP1 = ptrQ + 1'b1;

  assign linkE = pcE + `XLEN'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      ptrQ <= '0;
    end else begin
      // Stall already folded into every event
      ptrQ <= ptrNext;
    end
  end

  //////////////////////////////////////////////////
  // Stack storage
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RAS_DEPTH; i++) begin
        stack[i] <= '0;
      end
    end else if (push) begin
      stack[ptrP1] <= linkE;
    end
  end

  // Top of stack feeds fetch in the same cycle
  assign rasTargetF = stack[ptrQ];

endmodule

/* verilog/returnPredictTop.sv */
// Top level of the return prediction slice, class table, pipe, decoder and stack
`timescale 1ns/1ps

`include "bp_defines.svh"

module returnPredictTop import bpPkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  input  logic             flushE,
  input  logic [`XLEN-1:0] pcF,
  input  instrWordU        instrF,
  output instrClassT       predClassF,
  output logic [`XLEN-1:0] rasTargetF,
  output logic             classMissD
);

  // Decode stage
  logic [`XLEN-1:0] pcD;
  instrWordU        instrD;
  instrClassT       predClassD;
  instrClassT       classD;

  // Execute stage
  logic [`XLEN-1:0] pcE;
  instrClassT       classE;
  logic             validE;

  // Table write enable
  logic             update;

  //////////////////////////////////////////////////
  // Training only on a real miss that moves on
  assign update = classMissD & ~stall;

  classPredictor classPred0 (
    .clk        (clk),
    .reset      (reset),
    .pcF        (pcF),
    .predClassF (predClassF),
    .pcD        (pcD),
    .classD     (classD),
    .update     (update)
  );

  // D valid is already folded into classMissD
  predictPipe pipe0 (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .flushE     (flushE),
    .pcF        (pcF),
    .instrF     (instrF),
    .predClassF (predClassF),
    .classD     (classD),
    .pcD        (pcD),
    .instrD     (instrD),
    .predClassD (predClassD),
    .validD     (),
    .classMissD (classMissD),
    .pcE        (pcE),
    .classE     (classE),
    .validE     (validE)
  );

  instrClassDecode decode0 (
    .instrD (instrD),
    .classD (classD)
  );

  rasPredictor ras0 (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .predClassF (predClassF),
    .predClassD (predClassD),
    .classD     (classD),
    .classMissD (classMissD),
    .classE     (classE),
    .validE     (validE),
    .pcE        (pcE),
    .rasTargetF (rasTargetF)
  );

endmodule

/* tb/returnPredictAsserts.sv */
// Bound checks of predicted class, return target, class miss and stall hold
`timescale 1ns/1ps

`include "bp_defines.svh"

module returnPredictAsserts import bpPkg::*; (
  input logic             clk,
  input logic             reset,
  input logic             stall,
  input logic [`XLEN-1:0] pcF,
  input instrClassT       predClassF,
  input logic [`XLEN-1:0] rasTargetF,
  input logic             classMissD,
  // Reference model values
  input logic             chkEn,
  input instrClassT       expPred,
  input logic [`XLEN-1:0] expTarget,
  input logic             expMiss,
  input logic [127:0]     testName
);

  // Read by the testbench after every edge
  int failCount = 0;

  //////////////////////////////////////////////////
  // Outputs against the model
  classMatch: assert property (@(posedge clk) disable iff (reset)
    chkEn |-> (predClassF == expPred))
    else begin
      failCount++;
      $error("FAIL %0s predClassF expected %h actual %h",
             testName, $sampled(expPred), $sampled(predClassF));
    end

  targetMatch: assert property (@(posedge clk) disable iff (reset)
    chkEn |-> (rasTargetF == expTarget))
    else begin
      failCount++;
      $error("FAIL %0s rasTargetF expected %h actual %h",
             testName, $sampled(expTarget), $sampled(rasTargetF));
    end

  missMatch: assert property (@(posedge clk) disable iff (reset)
    chkEn |-> (classMissD == expMiss))
    else begin
      failCount++;
      $error("FAIL %0s classMissD expected %b actual %b",
             testName, $sampled(expMiss), $sampled(classMissD));
    end

  //////////////////////////////////////////////////
  // Stall freezes the stack and the table
  stallHoldTarget: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(rasTargetF))
    else begin
      failCount++;
      $error("FAIL %0s rasTargetF moved under stall", testName);
    end

  // Same fetch PC under stall, same prediction
  stallHoldClass: assert property (@(posedge clk) disable iff (reset)
    stall |=> (!$stable(pcF) || $stable(predClassF)))
    else begin
      failCount++;
      $error("FAIL %0s predClassF moved under stall", testName);
    end

endmodule

/* tb/returnPredictTb.sv */
// Testbench with clock, reset, LFSR, reference model and return prediction stimulus
`timescale 1ns/1ps

`include "bp_defines.svh"

module returnPredictTb import bpPkg::*; ();

  logic             clk;
  logic             reset;
  logic             stall;
  logic             flushE;
  logic [`XLEN-1:0] pcF;
  instrWordU        instrF;
  instrClassT       predClassF;
  logic [`XLEN-1:0] rasTargetF;
  logic             classMissD;

  // Expected values for the bound checks
  logic             chkEn;
  instrClassT       expPred;
  logic [`XLEN-1:0] expTarget;
  logic             expMiss;
  logic [127:0]     testName;

  // Reference model of table, stack and stages
  instrClassT       mTable [`CLASS_DEPTH];
  logic [`XLEN-1:0] mStack [`RAS_DEPTH];
  logic [$clog2(`RAS_DEPTH)-1:0] mPtr;
  logic             mValidD;
  logic             mValidE;
  logic [`XLEN-1:0] mPcD;
  logic [`XLEN-1:0] mPcE;
  logic [31:0]      mInstrD;
  instrClassT       mPredD;
  instrClassT       mClassE;

  logic [15:0]      lfsr;
  logic             sawMiss;
  logic [31:0]      pcCall;
  logic [31:0]      pcRet;
  logic [31:0]      pcNew;
  logic [31:0]      nestPc [3];

  returnPredictTop dut0 (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .flushE     (flushE),
    .pcF        (pcF),
    .instrF     (instrF),
    .predClassF (predClassF),
    .rasTargetF (rasTargetF),
    .classMissD (classMissD)
  );

  bind returnPredictTop returnPredictAsserts asserts0 (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .pcF        (pcF),
    .predClassF (predClassF),
    .rasTargetF (rasTargetF),
    .classMissD (classMissD),
    .chkEn      (returnPredictTb.chkEn),
    .expPred    (returnPredictTb.expPred),
    .expTarget  (returnPredictTb.expTarget),
    .expMiss    (returnPredictTb.expMiss),
    .testName   (returnPredictTb.testName)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abortRun(input string why);
    $display("ERROR: %s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  // Overall cycle limit
  initial begin
    repeat (1000) @(posedge clk);
    abortRun("the run exceeded its cycle limit");
  end

  //////////////////////////////////////////////////
  // Class of an instruction word, from the RV32I encodings
  function automatic instrClassT refClass(input logic [31:0] w);
    instrClassT c;
    logic rdLink;
    logic rs1Link;
    c = '0;
    rdLink  = (w[11:7] == 5'd1) || (w[11:7] == 5'd5);
    rs1Link = (w[19:15] == 5'd1) || (w[19:15] == 5'd5);
    if (w[6:0] == 7'h6f) begin
      c.call = rdLink;
      c.jump = !rdLink;
    end else if (w[6:0] == 7'h67 && w[14:12] == 3'd0) begin
      c.ret  = rs1Link && (w[11:7] == 5'd0);
      c.call = !c.ret && rdLink;
      c.jump = !c.ret && !rdLink;
    end else if (w[6:0] == 7'h63) begin
      c.branch = 1'b1;
    end
    return c;
  endfunction

  function automatic logic [31:0] jalWord(input logic [4:0] rd);
    return {20'h00100, rd, 7'h6f};
  endfunction

  function automatic logic [31:0] jalrWord(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'h000, rs1, 3'd0, rd, 7'h67};
  endfunction

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Random upper bits, chosen table index
  task automatic randPc(input logic [3:0] idx, output logic [31:0] pc);
    logic [31:0] r;
    takeBits(26, r);
    pc = {r[25:0], idx, 2'b00};
  endtask

  //////////////////////////////////////////////////
  // One cycle: drive, publish expectations, advance the model at the edge
  task automatic step(input logic [31:0] pc, input logic [31:0] instr,
                      input logic st, input logic fl);
    instrClassT cD;
    logic pop;
    logic push;
    logic up;
    logic down;
    pcF = pc;
    instrF = instr;
    stall = st;
    flushE = fl;
    cD = refClass(mInstrD);
    expPred = mTable[pc[5:2]];
    expTarget = mStack[mPtr];
    expMiss = mValidD && !fl && (cD != mPredD);
    #1;
    sawMiss = classMissD;
    @(posedge clk);
    #2;
    if (dut0.asserts0.failCount != 0) abortRun("a bound assertion failed");
    pop  = expPred.ret && !st;
    push = mClassE.call && mValidE && !fl && !st;
    up   = expMiss && !st && mPredD.ret && !cD.ret;
    down = expMiss && !st && !mPredD.ret && cD.ret;
    // Push lands above the old top
    if (push) mStack[mPtr + 1'b1] = mPcE + 32'd4;
    mPtr = mPtr + 3'(push) + 3'(up) - 3'(pop) - 3'(down);
    if (expMiss && !st) mTable[mPcD[5:2]] = cD;
    if (fl) begin
      mValidD = 1'b0;
      mValidE = 1'b0;
    end else if (!st) begin
      mValidE = mValidD;
      mValidD = 1'b1;
    end
    if (!st) begin
      mPcE = mPcD;
      mClassE = cD;
      mPcD = pc;
      mInstrD = instr;
      mPredD = expPred;
    end
  endtask

  // Class-free filler at table entries 12 to 15
  task automatic fill(input int n);
    logic [31:0] r;
    logic [31:0] pc;
    for (int i = 0; i < n; i++) begin
      takeBits(25, r);
      randPc({2'b11, r[1:0]}, pc);
      step(pc, {r[24:0], 7'h13}, 1'b0, 1'b0);
    end
  endtask

  // Filler cycles until D flags a miss
  task automatic expectMiss(input int limit);
    int n;
    n = 0;
    do begin
      if (n == limit) abortRun("no class miss was flagged for a new control transfer");
      fill(1);
      n++;
    end while (!sawMiss);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  initial begin
    lfsr = 16'd79;
    reset = 1'b1;
    stall = 1'b0;
    flushE = 1'b0;
    pcF = '0;
    instrF = 32'h00000013;
    chkEn = 1'b0;
    expPred = '0;
    expTarget = '0;
    expMiss = 1'b0;
    testName = "reset";
    for (int i = 0; i < `CLASS_DEPTH; i++) mTable[i] = '0;
    for (int i = 0; i < `RAS_DEPTH; i++) mStack[i] = '0;
    mPtr = '0;
    mValidD = 1'b0;
    mValidE = 1'b0;
    mPcD = '0;
    mPcE = '0;
    mInstrD = 32'h00000013;
    mPredD = '0;
    mClassE = '0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    chkEn = 1'b1;
    fill(2);

    // First sight of a call and a return misses, second sight predicts
    testName = "training";
    randPc(4'd1, pcCall);
    randPc(4'd2, pcRet);
    step(pcCall, jalWord(5'd1), 1'b0, 1'b0);
    expectMiss(3);
    step(pcRet, jalrWord(5'd0, 5'd1), 1'b0, 1'b0);
    expectMiss(3);
    step(pcCall, jalWord(5'd1), 1'b0, 1'b0);
    fill(3);

    testName = "callReturn";
    randPc(4'd3, pcNew);
    step(pcNew, jalWord(5'd1), 1'b0, 1'b0);
    fill(3);
    step(pcRet, jalrWord(5'd0, 5'd1), 1'b0, 1'b0);
    fill(2);

    // Three deep, then an unpredicted return at entry 7
    testName = "nesting";
    for (int i = 0; i < 3; i++) begin
      randPc(4'(4 + i), nestPc[i]);
      step(nestPc[i], jalrWord(5'd5, 5'd6), 1'b0, 1'b0);
      fill(2);
    end
    repeat (3) begin
      step(pcRet, jalrWord(5'd0, 5'd1), 1'b0, 1'b0);
      fill(2);
    end
    step(nestPc[0], jalrWord(5'd5, 5'd6), 1'b0, 1'b0);
    step(nestPc[1], jalrWord(5'd5, 5'd6), 1'b0, 1'b0);
    fill(2);
    randPc(4'd7, pcNew);
    step(pcNew, jalrWord(5'd0, 5'd5), 1'b0, 1'b0);
    fill(2);
    step(pcRet, jalrWord(5'd0, 5'd1), 1'b0, 1'b0);
    fill(2);

    // Stall over a call in E and a new call missing in D
    // Then flushes of calls in D and in E
    testName = "stallFlush";
    randPc(4'd8, pcNew);
    step(pcCall, jalWord(5'd1), 1'b0, 1'b0);
    step(pcNew, jalWord(5'd1), 1'b0, 1'b0);
    repeat (2) step(pcNew, jalWord(5'd1), 1'b1, 1'b0);
    repeat (2) step(pcRet, jalrWord(5'd0, 5'd1), 1'b1, 1'b0);
    fill(3);
    randPc(4'd3, pcNew);
    step(pcNew, jalWord(5'd1), 1'b0, 1'b0);
    step(32'h30, 32'h00000013, 1'b0, 1'b1);
    step(pcNew, jalWord(5'd1), 1'b0, 1'b0);
    fill(1);
    step(32'h30, 32'h00000013, 1'b0, 1'b1);
    fill(2);
    step(pcRet, jalrWord(5'd0, 5'd1), 1'b0, 1'b0);
    fill(2);

    if (dut0.asserts0.failCount == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      abortRun("bound assertions reported failures");
    end
  end

endmodule

/* all.f */
+incdir+include
verilog/bpPkg.sv
verilog/instrClassDecode.sv
verilog/classPredictor.sv
verilog/predictPipe.sv
verilog/rasPredictor.sv
verilog/returnPredictTop.sv
tb/returnPredictAsserts.sv
tb/returnPredictTb.sv

/* Makefile */
# Verilator build and run of the return prediction testbench

VERILATOR ?= verilator
TOP       ?= returnPredictTb
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(RUNFLAGS) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(BUILD_DIR)
